// ==== source/patch_types_pkg.sv ====
// pixel, patch and stored-word types, imported by the patch store RTL and its testbench
package patch_types_pkg;

  // pixel geometry
  localparam int PIXEL_WIDTH = 11;
  localparam int PATCH_SIZE = 5;
  localparam int PATCH_BITS = PIXEL_WIDTH * PATCH_SIZE;

  // one stored entry spans two 32-bit slices
  localparam int WORD_SLICES = 2;
  localparam int WORD_WIDTH = 64;

  typedef logic [PIXEL_WIDTH-1:0] pixel_t;

  // pixel 0 in the low bits
  typedef pixel_t [PATCH_SIZE-1:0] patch_pixels_t;

  // pixel view, zero pad above the patch
  typedef struct packed {
    logic [WORD_WIDTH-PATCH_BITS-1:0] pad;
    patch_pixels_t                    pixels;
  } patch_pix_view_t;

  // same stored word, read as pixels or as macro slices (slice 0 low)
  typedef union packed {
    patch_pix_view_t                                     pix;
    logic [WORD_SLICES-1:0][WORD_WIDTH/WORD_SLICES-1:0] slice;
  } patch_word_t;

endpackage

// ==== source/sram_macro_pkg.sv ====
// geometry of the 32x256 1rw1r SRAM macro, imported by the memory and its model
package sram_macro_pkg;

  // data bits per macro word
  localparam int MACRO_WIDTH = 32;

  // entries per macro
  localparam int MACRO_DEPTH = 256;
  localparam int MACRO_ADDR_WIDTH = 8;

  // one mask bit per byte
  localparam int MACRO_MASK_WIDTH = MACRO_WIDTH / 8;

  typedef logic [MACRO_WIDTH-1:0] macro_word_t;

endpackage

// ==== source/sram_1rw1r.sv ====
// behavioral stand-in for the 32x256 SRAM macro, one rw port and one read port
`timescale 1ns/1ns

module sram_1rw1r
  import sram_macro_pkg::*;
(
  input  logic                        clk,
  input  logic                        csb0,
  input  logic                        web0,
  input  logic [MACRO_MASK_WIDTH-1:0] wmask0,
  input  logic [MACRO_ADDR_WIDTH-1:0] addr0,
  input  macro_word_t                 din0,
  output macro_word_t                 dout0,
  input  logic                        csb1,
  input  logic [MACRO_ADDR_WIDTH-1:0] addr1,
  output macro_word_t                 dout1
);

  // storage array
  macro_word_t mem [MACRO_DEPTH];

  // port 0: masked byte write, or registered read
  always_ff @(posedge clk) begin
    if (!csb0) begin
      if (!web0) begin
        for (int b = 0; b < MACRO_MASK_WIDTH; b++) begin
          if (wmask0[b]) begin
            mem[addr0][b*8 +: 8] <= din0[b*8 +: 8];
          end
        end
      end else begin
        dout0 <= mem[addr0];
      end
    end
  end

  // port 1: read only
  // sees the old word on a same-edge write
  always_ff @(posedge clk) begin
    if (!csb1) begin
      dout1 <= mem[addr1];
    end
  end

  // a write strobe is only meaningful with the chip select
  a_web0_needs_csb0 : assert property (@(posedge clk) !web0 |-> !csb0);

endmodule

// ==== source/query_patch_mem.sv ====
// banked query patch memory of 1rw1r macro pairs that the patch store top level instances
`timescale 1ns/1ns

module query_patch_mem
  import patch_types_pkg::*;
  import sram_macro_pkg::*;
#(
  parameter int NUM_BANKS = 2,
  localparam int BANK_BITS = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1,
  localparam int PATCH_ADDR_WIDTH = MACRO_ADDR_WIDTH + BANK_BITS
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        wr_en,
  input  logic [PATCH_ADDR_WIDTH-1:0] wr_addr,
  input  patch_pixels_t               wr_patch,
  input  logic                        rd_en,
  input  logic [PATCH_ADDR_WIDTH-1:0] rd_addr,
  output patch_pixels_t               rd_patch,
  output logic                        rd_valid
);

  // macros side by side per bank
  localparam int SLICES = $bits(patch_word_t) / MACRO_WIDTH;

  // bank field is the top of the patch address
  logic [BANK_BITS-1:0] wr_bank;
  logic [BANK_BITS-1:0] rd_bank;
  // active-low per-bank selects
  logic [NUM_BANKS-1:0] wr_csb;
  logic [NUM_BANKS-1:0] rd_csb;

  patch_word_t wr_word;
  patch_word_t rd_word;
  macro_word_t rd_slice [NUM_BANKS][SLICES];

  // read pipeline control
  logic                 rd_en_q;
  logic [BANK_BITS-1:0] rd_bank_q;

  assign wr_bank = wr_addr[PATCH_ADDR_WIDTH-1 -: BANK_BITS];
  assign rd_bank = rd_addr[PATCH_ADDR_WIDTH-1 -: BANK_BITS];

  // pad stays zero in storage
  always_comb begin
    wr_word = '0;
    wr_word.pix.pixels = wr_patch;
  end

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    assign wr_csb[b] = !(wr_en && (wr_bank == BANK_BITS'(b)));
    assign rd_csb[b] = !(rd_en && (rd_bank == BANK_BITS'(b)));

    for (genvar s = 0; s < SLICES; s++) begin : g_slice
      // port 0 only writes so csb0 and web0 share the select
      sram_1rw1r u_sram (
        .clk    (clk),
        .csb0   (wr_csb[b]),
        .web0   (wr_csb[b]),
        .wmask0 ({MACRO_MASK_WIDTH{1'b1}}),
        .addr0  (wr_addr[MACRO_ADDR_WIDTH-1:0]),
        .din0   (wr_word.slice[s]),
        .dout0  (),
        .csb1   (rd_csb[b]),
        .addr1  (rd_addr[MACRO_ADDR_WIDTH-1:0]),
        .dout1  (rd_slice[b][s])
      );
    end
  end

  // bank and strobe follow the macro read by one edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_en_q   <= 1'b0;
      rd_bank_q <= '0;
    end else begin
      rd_en_q <= rd_en;
      if (rd_en) begin
        rd_bank_q <= rd_bank;
      end
    end
  end

  // pick the slices of the bank that was read
  always_comb begin
    for (int s = 0; s < SLICES; s++) begin
      rd_word.slice[s] = rd_slice[rd_bank_q][s];
    end
  end

  // output register holds its value between reads
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_patch <= '0;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en_q;
      if (rd_en_q) begin
        rd_patch <= rd_word.pix.pixels;
      end
    end
  end

  a_one_bank_per_port : assert property (@(posedge clk) disable iff (!arst_n)
    $countones(~wr_csb) <= 1 && $countones(~rd_csb) <= 1);

endmodule

// ==== source/patch_write_ctrl.sv ====
// load address counter that turns incoming patches into port-0 writes for the patch memory
`timescale 1ns/1ns

module patch_write_ctrl
  import patch_types_pkg::*;
  import sram_macro_pkg::*;
#(
  parameter int NUM_BANKS = 2,
  localparam int BANK_BITS = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1,
  localparam int PATCH_ADDR_WIDTH = MACRO_ADDR_WIDTH + BANK_BITS
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        load_start,
  input  logic                        patch_valid,
  input  patch_pixels_t               patch_in,
  output logic                        wr_en,
  output logic [PATCH_ADDR_WIDTH-1:0] wr_addr,
  output patch_pixels_t               wr_patch,
  output logic [PATCH_ADDR_WIDTH:0]   patch_count,
  output logic                        full
);

  localparam int CAPACITY = NUM_BANKS * MACRO_DEPTH;

  // one extra bit so the count can reach capacity
  logic [PATCH_ADDR_WIDTH:0] load_cnt;
  // load_start rewinds the counter within the strobe cycle
  logic [PATCH_ADDR_WIDTH:0] base_cnt;

  assign base_cnt = load_start ? '0 : load_cnt;

  // write goes out in the strobe cycle
  assign wr_en    = patch_valid && (base_cnt != (PATCH_ADDR_WIDTH+1)'(CAPACITY));
  assign wr_addr  = base_cnt[PATCH_ADDR_WIDTH-1:0];
  assign wr_patch = patch_in;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      load_cnt <= '0;
    end else if (load_start || wr_en) begin
      load_cnt <= base_cnt + (PATCH_ADDR_WIDTH+1)'(wr_en);
    end
  end

  // full sticks until the next load_start
  assign full        = (load_cnt == (PATCH_ADDR_WIDTH+1)'(CAPACITY));
  assign patch_count = load_cnt;

  a_cnt_in_range : assert property (@(posedge clk) disable iff (!arst_n)
    load_cnt <= (PATCH_ADDR_WIDTH+1)'(CAPACITY));

endmodule

// ==== source/query_patch_top.sv ====
// query patch store top level, joins the write controller to the banked patch memory
`timescale 1ns/1ns

module query_patch_top
  import patch_types_pkg::*;
  import sram_macro_pkg::*;
#(
  parameter int NUM_BANKS = 2,
  localparam int BANK_BITS = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1,
  localparam int PATCH_ADDR_WIDTH = MACRO_ADDR_WIDTH + BANK_BITS
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        load_start,
  input  logic                        patch_valid,
  input  patch_pixels_t               patch_in,
  output logic                        full,
  output logic [PATCH_ADDR_WIDTH:0]   patch_count,
  input  logic                        rd_en,
  input  logic [PATCH_ADDR_WIDTH-1:0] rd_addr,
  output patch_pixels_t               rd_patch,
  output logic                        rd_valid
);

  // controller to memory write port
  logic                        wr_en;
  logic [PATCH_ADDR_WIDTH-1:0] wr_addr;
  patch_pixels_t               wr_patch;

  patch_write_ctrl #(
    .NUM_BANKS (NUM_BANKS)
  ) u_write_ctrl (
    .clk         (clk),
    .arst_n      (arst_n),
    .load_start  (load_start),
    .patch_valid (patch_valid),
    .patch_in    (patch_in),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_patch    (wr_patch),
    .patch_count (patch_count),
    .full        (full)
  );

  // read side comes straight from outside
  query_patch_mem #(
    .NUM_BANKS (NUM_BANKS)
  ) u_patch_mem (
    .clk      (clk),
    .arst_n   (arst_n),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_patch (wr_patch),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_patch (rd_patch),
    .rd_valid (rd_valid)
  );

endmodule

// ==== test/clock_gen.sv ====
// testbench clock and reset source, instanced once by the patch store testbench
`timescale 1ns/1ns

module clock_gen #(
  parameter int PERIOD = 40,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // reset held low over the first rising edges, released mid-cycle
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

// ==== test/query_patch_tb.sv ====
// randomized testbench that checks loads and reads of the query patch store against a local model
`timescale 1ns/1ns

module query_patch_tb
  import patch_types_pkg::*;
();

  localparam int NUM_BANKS = 2;
  localparam int ADDR_W = 9;
  localparam int CAPACITY = 512;

  typedef logic [ADDR_W:0] count_t;

  // one expected read result and the edge where the output register takes it
  typedef struct packed {
    patch_pixels_t data;
    int            due;
  } exp_read_t;

  logic          clk;
  logic          arst_n;
  logic          load_start;
  logic          patch_valid;
  patch_pixels_t patch_in;
  logic          full;
  count_t        patch_count;
  logic          rd_en;
  logic [ADDR_W-1:0] rd_addr;
  patch_pixels_t rd_patch;
  logic          rd_valid;

  // reference model
  patch_pixels_t mem_model [int];
  int            model_cnt;
  exp_read_t     exp_q [$];
  int            edge_cnt;

  int mismatch_errors;
  int other_errors;

  clock_gen #(
    .PERIOD       (40),
    .RESET_CYCLES (2)
  ) u_clock_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  query_patch_top #(
    .NUM_BANKS (NUM_BANKS)
  ) query_patch_top_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .load_start  (load_start),
    .patch_valid (patch_valid),
    .patch_in    (patch_in),
    .full        (full),
    .patch_count (patch_count),
    .rd_en       (rd_en),
    .rd_addr     (rd_addr),
    .rd_patch    (rd_patch),
    .rd_valid    (rd_valid)
  );

  task automatic check_patch(input patch_pixels_t got, input patch_pixels_t exp,
                             input string what);
    if (got !== exp) begin
      mismatch_errors++;
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input count_t got, input count_t exp);
    if (got !== exp) begin
      mismatch_errors++;
      $display("MISMATCH at %0t ns: patch_count is %0d, expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      mismatch_errors++;
      $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  function automatic patch_pixels_t rand_patch();
    patch_pixels_t p;
    for (int i = 0; i < PATCH_SIZE; i++) begin
      p[i] = pixel_t'($urandom);
    end
    return p;
  endfunction

  function automatic logic chance(input int pct);
    return $urandom_range(0, 99) < pct;
  endfunction

  // entries are always filled from 0 upward, so the keys are contiguous
  function automatic int pick_addr();
    if (mem_model.size() == 0) begin
      return 0;
    end
    return $urandom_range(0, mem_model.size() - 1);
  endfunction

  // model update at the rising edge and checks at the falling edge
  task automatic run_cycle();
    int        base;
    exp_read_t rd;
    @(posedge clk);
    edge_cnt++;
    base = load_start ? 0 : model_cnt;
    // read sees the contents from before this edge's write
    if (rd_en) begin
      rd.data = mem_model[int'(rd_addr)];
      rd.due = edge_cnt + 1;
      exp_q.push_back(rd);
    end
    if (patch_valid && base != CAPACITY) begin
      mem_model[base] = patch_in;
      base++;
    end
    model_cnt = base;
    @(negedge clk);
    check_count(patch_count, count_t'(model_cnt));
    check_flag(full, model_cnt == CAPACITY, "full");
    if (exp_q.size() > 0 && exp_q[0].due == edge_cnt) begin
      rd = exp_q.pop_front();
      check_flag(rd_valid, 1'b1, "rd_valid");
      check_patch(rd_patch, rd.data, "rd_patch");
    end else begin
      check_flag(rd_valid, 1'b0, "rd_valid");
    end
  endtask

  // called at a falling edge
  task automatic drive(input logic ls, input logic pv, input logic re, input int addr);
    load_start = ls;
    patch_valid = pv;
    patch_in = rand_patch();
    rd_en = re;
    rd_addr = re ? ADDR_W'(addr) : '0;
    run_cycle();
  endtask

  task automatic drain_reads();
    int n;
    n = 0;
    while (exp_q.size() > 0 && n < 10) begin
      drive(1'b0, 1'b0, 1'b0, 0);
      n++;
    end
    if (exp_q.size() > 0) begin
      other_errors++;
      $display("read results still pending after %0d idle cycles", n);
    end
  endtask

  initial begin
    int wait_cnt;
    int seed_val;
    int k;
    load_start = 1'b0;
    patch_valid = 1'b0;
    patch_in = '0;
    rd_en = 1'b0;
    rd_addr = '0;
    mismatch_errors = 0;
    other_errors = 0;
    model_cnt = 0;
    edge_cnt = 0;
    seed_val = $urandom(32'h764adb56);

    wait_cnt = 0;
    while (arst_n !== 1'b1 && wait_cnt < 20) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (arst_n !== 1'b1) begin
      other_errors++;
      $display("reset was not released within %0d cycles", wait_cnt);
    end
    // reset values
    check_count(patch_count, '0);
    check_flag(full, 1'b0, "full after reset");
    check_flag(rd_valid, 1'b0, "rd_valid after reset");
    check_patch(rd_patch, patch_pixels_t'(0), "rd_patch after reset");

    // fill to capacity with random gaps and reads mixed in
    drive(1'b1, 1'b0, 1'b0, 0);
    wait_cnt = 0;
    while (full !== 1'b1 && wait_cnt < 4 * CAPACITY) begin
      drive(1'b0, chance(70), mem_model.size() > 0 && chance(30), pick_addr());
      wait_cnt++;
    end
    if (full !== 1'b1) begin
      other_errors++;
      $display("full did not rise within %0d cycles", wait_cnt);
    end

    // strobes while full must be dropped
    repeat (20) drive(1'b0, 1'b1, chance(50), pick_addr());
    // a leaked strobe would land on the wrapped address 0
    drive(1'b0, 1'b0, 1'b1, 0);

    // back to back reads that alternate banks
    for (int i = 0; i < 64; i++) begin
      if (i % 2 == 0) begin
        drive(1'b0, 1'b0, 1'b1, $urandom_range(0, CAPACITY / 2 - 1));
      end else begin
        drive(1'b0, 1'b0, 1'b1, $urandom_range(CAPACITY / 2, CAPACITY - 1));
      end
    end
    drain_reads();

    // reload where the first patch in the load_start cycle lands in entry 0
    drive(1'b1, 1'b1, 1'b0, 0);
    wait_cnt = 0;
    while (model_cnt < 40 && wait_cnt < 400) begin
      drive(1'b0, chance(60), chance(25), pick_addr());
      wait_cnt++;
    end
    if (model_cnt < 40) begin
      other_errors++;
      $display("reload stalled at %0d patches", model_cnt);
    end
    // older entries above the reload keep the first load's data
    repeat (16) drive(1'b0, 1'b0, 1'b1, $urandom_range(model_cnt, CAPACITY - 1));
    repeat (16) drive(1'b0, 1'b0, 1'b1, $urandom_range(0, model_cnt - 1));
    drain_reads();

    // read of the entry under write returns the old word and then the new one
    repeat (4) begin
      k = model_cnt;
      drive(1'b0, 1'b1, 1'b1, k);
      drive(1'b0, 1'b0, 1'b1, k);
      drive(1'b0, 1'b0, 1'b0, 0);
    end
    drain_reads();

    $display("errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
    if (mismatch_errors + other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
source/patch_types_pkg.sv
source/sram_macro_pkg.sv
source/sram_1rw1r.sv
source/query_patch_mem.sv
source/patch_write_ctrl.sv
source/query_patch_top.sv
test/clock_gen.sv
test/query_patch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the query patch store testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module query_patch_tb -f sources.f || exit 1
sim_out="$(./obj_dir/Vquery_patch_tb)"
echo "$sim_out"
echo "$sim_out" | grep -qx "Finished with no errors" && echo "simulation passed" && exit 0 \
  || { echo "simulation failed"; exit 1; }
